// ==== compile.f ====
+incdir+rtl
rtl/exStagePkg.sv
rtl/aluUnit.sv
rtl/predicateRegs.sv
rtl/mslUnit.sv
rtl/resultWriteback.sv
rtl/exStage.sv
tests/exStage_checker.sv
tests/exStageTb.sv

// ==== rtl/aluUnit.sv ====
// Add, subtract and conditional move datapath with compare condition decode
`timescale 1ns/100ps
`include "exStage_cfg.svh"

module aluUnit
  import exStagePkg::*;
(
  input  aluReq_t                req,
  input  logic                   flagReg,    // Registered flag for cmov
  output logic [`DATA_WIDTH-1:0] aluResult,
  output logic                   cmpValid,   // Opcode is a compare
  output logic                   cmpResult
);

  // N+1 bit operands so the top bit of the difference is the borrow
  logic [`DATA_WIDTH:0] aExt;
  logic [`DATA_WIDTH:0] bExt;
  logic [`DATA_WIDTH:0] bSel;
  logic [`DATA_WIDTH:0] sum;

  logic isAdd;
  logic isSub;
  logic isCmov;
  logic notZero;
  logic borrow;

  // ************************************************************
  // Opcode decode
  // ************************************************************

  assign isAdd    = (req.op.code == `ALU_OP_ADD);
  assign isCmov   = (req.op.code == `ALU_OP_CMOV);
  assign isSub    = !isAdd;  // Everything but ADD subtracts
  assign cmpValid = !(isAdd || (req.op.code == `ALU_OP_SUB) || isCmov);

  // ************************************************************
  // Adder
  // ************************************************************

  // Sign extend unless the unsigned bit is set
  assign aExt = req.op.cmp.isUnsigned ? {1'b0, req.a} : {req.a[`DATA_WIDTH-1], req.a};
  assign bExt = req.op.cmp.isUnsigned ? {1'b0, req.b} : {req.b[`DATA_WIDTH-1], req.b};

  assign bSel = isSub ? ~bExt : bExt;                       // Two's complement B
  assign sum  = aExt + bSel + {{`DATA_WIDTH{1'b0}}, isSub}; // Carry in for subtract

  always_comb
  begin
    if (isCmov)
      aluResult = flagReg ? req.a : req.b;  // Flag from previous edge
    else
      aluResult = sum[`DATA_WIDTH-1:0];     // Low word only
  end

  // ************************************************************
  // Compare conditions
  // ************************************************************

  assign notZero = |sum[`DATA_WIDTH-1:0];  // A != B
  assign borrow  = sum[`DATA_WIDTH];       // A < B, no overflow in N+1 bits

  always_comb
  begin
    case (req.op.cmp.cond)
      `CMP_EQ: cmpResult = !notZero;
      `CMP_NE: cmpResult = notZero;
      `CMP_LE: cmpResult = borrow || !notZero;
      `CMP_LT: cmpResult = borrow;
      `CMP_GE: cmpResult = !borrow;
      `CMP_GT: cmpResult = !borrow && notZero;
      default: cmpResult = 1'b0;  // Reserved conds read false
    endcase
  end

endmodule

// ==== rtl/exStage.sv ====
// Execution stage top level joining ALU, predicates, MSL unit and write-back
`timescale 1ns/100ps
`include "exStage_cfg.svh"

module exStage
  import exStagePkg::*;
(
  input  logic        iClk,
  input  logic        rstN,
  input  exIssue_t    issue,   // Instruction in EX, new every clock
  output predicates_t preds,
  output exBypass_t   bypass,
  output wbResult_t   wb
);

  logic [`DATA_WIDTH-1:0] aluResult;
  logic [`DATA_WIDTH-1:0] mslResult;
  logic [`DATA_WIDTH-1:0] shadow;
  logic                   cmpValid;
  logic                   cmpResult;
  logic                   flagReg;  // Unforwarded flag back to ALU

  // ************************************************************
  // Units
  // ************************************************************

  aluUnit uAlu (
    .req       (issue.alu),
    .flagReg   (flagReg),
    .aluResult (aluResult),
    .cmpValid  (cmpValid),
    .cmpResult (cmpResult)
  );

  predicateRegs uPred (
    .iClk      (iClk),
    .rstN      (rstN),
    .cmpValid  (cmpValid),
    .cmpResult (cmpResult),
    .upd       (issue.upd),
    .preds     (preds),
    .flagReg   (flagReg)
  );

  mslUnit uMsl (
    .req       (issue.msl),
    .mslResult (mslResult)
  );

  resultWriteback uWb (
    .iClk      (iClk),
    .rstN      (rstN),
    .ctl       (issue.wbCtl),
    .aluResult (aluResult),
    .mslResult (mslResult),
    .wb        (wb),
    .shadow    (shadow)
  );

  // Bypass sources
  assign bypass.aluResult = aluResult;
  assign bypass.mslResult = mslResult;
  assign bypass.shadow    = shadow;

endmodule

// ==== rtl/exStagePkg.sv ====
// ALU opcode union and the packed structs passed between execution stage units
`include "exStage_cfg.svh"

package exStagePkg;

  // ************************************************************
  // Opcode views
  // ************************************************************

  // Compare reading of the ALU opcode
  typedef struct packed {
    logic       isUnsigned;  // Zero extend both operands
    logic [2:0] cond;        // EQ/NE/LE/LT/GE/GT
  } aluCmp_t;

  // Same word, matched whole against ADD/SUB/CMOV or split as a compare
  typedef union packed {
    logic [`ALU_OP_WIDTH-1:0] code;
    aluCmp_t                  cmp;
  } aluOp_u;

  // ************************************************************
  // Issue bundle
  // ************************************************************

  typedef struct packed {
    aluOp_u                 op;
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
  } aluReq_t;                // 68 bits

  typedef struct packed {
    logic [`MSL_OP_WIDTH-1:0] op;
    logic [`DATA_WIDTH-1:0]   a;
    logic [`DATA_WIDTH-1:0]   b;  // Low bits double as shift amount
  } mslReq_t;                     // 67 bits

  typedef struct packed {
    logic updFlag;
    logic updP0;
    logic updP1;
  } predUpdate_t;

  typedef struct packed {
    logic [`RF_INDEX_WIDTH-1:0] rfAddr;
    logic                       rfWe;
    logic                       selMsl;       // Write back MSL result
    logic                       writeShadow;  // Also load R31 shadow
  } wbCtl_t;

  // Whole instruction in EX, all enables clear means bubble
  typedef struct packed {
    aluReq_t     alu;
    mslReq_t     msl;
    predUpdate_t upd;
    wbCtl_t      wbCtl;
  } exIssue_t;               // 146 bits

  // ************************************************************
  // Stage outputs
  // ************************************************************

  typedef struct packed {
    logic flag;
    logic p0;
    logic p1;
  } predicates_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] mslResult;
    logic [`DATA_WIDTH-1:0] shadow;
  } exBypass_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0]     data;
    logic [`RF_INDEX_WIDTH-1:0] addr;
    logic                       we;
  } wbResult_t;

endpackage

// ==== rtl/exStage_cfg.svh ====
// Datapath widths and the ALU and multiply/shift/logic opcode encodings
`ifndef EXSTAGE_CFG_SVH
`define EXSTAGE_CFG_SVH

// Datapath widths
`define DATA_WIDTH     32
`define RF_INDEX_WIDTH 5
// Shift amount comes from the low bits of operand B
`define SHAMT_WIDTH    5

// ALU opcodes
`define ALU_OP_WIDTH   4
`define ALU_OP_ADD     4'b0000
`define ALU_OP_SUB     4'b0001
`define ALU_OP_CMOV    4'b1000

// Compare conditions in opcode bits 2:0, bit 3 picks unsigned
`define CMP_EQ         3'b010
`define CMP_NE         3'b011
`define CMP_LE         3'b100
`define CMP_LT         3'b101
`define CMP_GE         3'b110
`define CMP_GT         3'b111

// Multiply/shift/logic opcodes, 3'b111 is reserved
`define MSL_OP_WIDTH   3
`define MSL_OP_AND     3'b000
`define MSL_OP_OR      3'b001
`define MSL_OP_XOR     3'b010
`define MSL_OP_MUL     3'b011
`define MSL_OP_SLL     3'b100
`define MSL_OP_SRL     3'b101
`define MSL_OP_SRA     3'b110

`endif

// ==== rtl/mslUnit.sv ====
// Multiply, shift and bitwise logic unit
`timescale 1ns/100ps
`include "exStage_cfg.svh"

module mslUnit
  import exStagePkg::*;
(
  input  mslReq_t                req,
  output logic [`DATA_WIDTH-1:0] mslResult
);

  logic [`SHAMT_WIDTH-1:0] shamt;
  logic [`DATA_WIDTH-1:0]  product;

  assign shamt   = req.b[`SHAMT_WIDTH-1:0];  // Upper bits of B ignored
  assign product = req.a * req.b;            // Low word of product

  // ************************************************************
  // Result mux
  // ************************************************************

  always_comb
  begin
    case (req.op)
      // Logic
      `MSL_OP_AND:
        mslResult = req.a & req.b;
      `MSL_OP_OR:
        mslResult = req.a | req.b;
      `MSL_OP_XOR:
        mslResult = req.a ^ req.b;

      // Multiply
      `MSL_OP_MUL:
        mslResult = product;

      // Shifts
      `MSL_OP_SLL:
        mslResult = req.a << shamt;
      `MSL_OP_SRL:
        mslResult = req.a >> shamt;
      `MSL_OP_SRA:
        mslResult = $signed(req.a) >>> shamt;  // Replicates sign bit

      // Reserved code falls back to AND
      default:
        mslResult = req.a & req.b;
    endcase
  end

endmodule

// ==== rtl/predicateRegs.sv ====
// Flag, P0 and P1 predicate registers with same cycle forwarding
`timescale 1ns/100ps

module predicateRegs
  import exStagePkg::*;
(
  input  logic        iClk,
  input  logic        rstN,
  input  logic        cmpValid,   // Compare in EX this cycle
  input  logic        cmpResult,
  input  predUpdate_t upd,
  output predicates_t preds,      // Forwarded view
  output logic        flagReg     // Raw flag register
);

  logic flagQ;
  logic p0Q;
  logic p1Q;

  logic flagWe;
  logic p0We;
  logic p1We;

  // Only a compare may touch a predicate
  assign flagWe = cmpValid && upd.updFlag;
  assign p0We   = cmpValid && upd.updP0;
  assign p1We   = cmpValid && upd.updP1;

  // ************************************************************
  // Registers
  // ************************************************************

  always_ff @(posedge iClk or negedge rstN)
  begin
    if (!rstN)
    begin
      flagQ <= 1'b0;
      p0Q   <= 1'b0;
      p1Q   <= 1'b0;
    end
    else
    begin
      if (flagWe)
        flagQ <= cmpResult;
      if (p0We)
        p0Q <= cmpResult;
      if (p1We)
        p1Q <= cmpResult;
    end
  end

  // New compare shows up the cycle it is written
  assign preds.flag = flagWe ? cmpResult : flagQ;
  assign preds.p0   = p0We   ? cmpResult : p0Q;
  assign preds.p1   = p1We   ? cmpResult : p1Q;

  // cmov sees the flag as of the last edge
  assign flagReg = flagQ;

endmodule

// ==== rtl/resultWriteback.sv ====
// Write-back result selection and the R31 shadow register
`timescale 1ns/100ps
`include "exStage_cfg.svh"

module resultWriteback
  import exStagePkg::*;
(
  input  logic                   iClk,
  input  logic                   rstN,
  input  wbCtl_t                 ctl,
  input  logic [`DATA_WIDTH-1:0] aluResult,
  input  logic [`DATA_WIDTH-1:0] mslResult,
  output wbResult_t              wb,
  output logic [`DATA_WIDTH-1:0] shadow     // R31 copy for bypass
);

  logic [`DATA_WIDTH-1:0] selData;

  // EX result, ALU unless the MSL unit is picked
  assign selData = ctl.selMsl ? mslResult : aluResult;

  // To WB stage, address and enable ride along unchanged
  assign wb.data = selData;
  assign wb.addr = ctl.rfAddr;
  assign wb.we   = ctl.rfWe;

  // ************************************************************
  // Shadow register
  // ************************************************************

  always_ff @(posedge iClk or negedge rstN)
  begin
    if (!rstN)
      shadow <= '0;
    else if (ctl.writeShadow)
      shadow <= selData;  // Visible one edge later
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the execution stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module exStageTb -f compile.f -Mdir obj_dir -o exStageSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/exStageSim +verilator+error+limit+100000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "PASS: all tests" "$LOG"; then
  exit 0
fi
echo "Simulation reported failure"
exit 1

// ==== tests/exStageTb.sv ====
// Testbench with clock, reset, directed and xorshift stimulus, watchdog and error summary
`timescale 1ns/100ps
`include "exStage_cfg.svh"

module exStageTb
  import exStagePkg::*;
();

  localparam int          CLK_PERIOD      = 100;
  localparam int          RESET_CYCLES    = 5;
  localparam int          DIRECTED_COUNT  = 41;   // 36 compares, 4 flag/cmov, 1 reserved MSL
  localparam int          RANDOM_COUNT    = 400;
  localparam int          WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_COUNT + RANDOM_COUNT + 20;
  localparam logic [31:0] SEED            = 32'hda36342d;

  logic        iClk;
  logic        rstN;
  exIssue_t    issue;
  predicates_t preds;
  exBypass_t   bypass;
  wbResult_t   wb;
  logic [31:0] rngState = SEED;
  int          errTotal;

  exStage UUT (
    .iClk   (iClk),
    .rstN   (rstN),
    .issue  (issue),
    .preds  (preds),
    .bypass (bypass),
    .wb     (wb)
  );

  initial iClk = 1'b0;
  always #(CLK_PERIOD / 2) iClk = ~iClk;

  // ************************************************************
  // Stimulus helpers
  // ************************************************************

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic driveBundle(input exIssue_t bundle);
    @(posedge iClk);
    issue <= bundle;
  endtask

  // Each cond, signed and unsigned, with equal, less and greater operands
  task automatic runDirected();
    exIssue_t    bundle;
    logic [31:0] lo;
    logic [31:0] hi;
    for (int c = 2; c < 8; c++)
      for (int u = 0; u < 2; u++)
        for (int r = 0; r < 3; r++)
        begin
          lo = (u == 1) ? 32'd3 : 32'hFFFF_FFFB;  // Smaller under this signedness
          hi = (u == 1) ? 32'hFFFF_FFFB : 32'd3;
          bundle = '0;
          bundle.alu.op.cmp.cond       = 3'(c);
          bundle.alu.op.cmp.isUnsigned = (u == 1);
          bundle.alu.a                 = (r == 2) ? hi : lo;
          bundle.alu.b                 = (r == 1) ? hi : lo;
          bundle.upd                   = {1'b1, r != 1, u == 1};  // Some bits left clear
          bundle.wbCtl.rfAddr          = 5'(c * 6 + u * 3 + r);
          bundle.wbCtl.rfWe            = 1'b1;
          bundle.wbCtl.writeShadow     = (r == 2);
          driveBundle(bundle);
        end
    // Set the flag, then cmov reads it one edge later
    bundle = '0;
    bundle.alu.op.code  = {1'b0, `CMP_GT};
    bundle.alu.a        = 32'd5;
    bundle.alu.b        = 32'd3;
    bundle.upd.updFlag  = 1'b1;
    driveBundle(bundle);
    bundle = '0;
    bundle.alu.op.code       = `ALU_OP_CMOV;
    bundle.alu.a             = 32'hAAAA_0001;
    bundle.alu.b             = 32'h5555_0002;
    bundle.wbCtl.rfWe        = 1'b1;
    bundle.wbCtl.writeShadow = 1'b1;
    driveBundle(bundle);
    // Clear the flag and cmov again
    bundle.alu.op.code  = {1'b0, `CMP_GT};
    bundle.alu.a        = 32'd3;
    bundle.alu.b        = 32'd5;
    bundle.upd.updFlag  = 1'b1;
    driveBundle(bundle);
    bundle.alu.op.code  = `ALU_OP_CMOV;
    bundle.upd.updFlag  = 1'b0;
    driveBundle(bundle);
    // Reserved MSL code
    bundle = '0;
    bundle.msl.op            = 3'b111;
    bundle.msl.a             = 32'hF0F0_3C3C;
    bundle.msl.b             = 32'hFF00_0FF0;
    bundle.wbCtl.selMsl      = 1'b1;
    bundle.wbCtl.writeShadow = 1'b1;
    driveBundle(bundle);
  endtask

  task automatic runRandom();
    exIssue_t    bundle;
    logic [31:0] ctl;
    logic [31:0] wordA;
    logic [31:0] wordB;
    for (int n = 0; n < RANDOM_COUNT; n++)
    begin
      rngState = nextRandom(rngState);
      ctl      = rngState;
      rngState = nextRandom(rngState);
      wordA    = rngState;
      rngState = nextRandom(rngState);
      wordB    = rngState;
      bundle.alu.op.code = ctl[3:0];
      bundle.alu.a       = wordA;
      bundle.alu.b       = (ctl[5:4] == 2'b00) ? wordA : wordB;  // Equal now and then
      bundle.msl.op      = ctl[8:6];
      bundle.msl.a       = wordB;
      bundle.msl.b       = wordA;
      bundle.upd         = ctl[11:9];
      bundle.wbCtl       = ctl[19:12];
      driveBundle(bundle);
    end
  endtask

  // ************************************************************
  // Main sequence
  // ************************************************************

  initial
  begin
    rstN  = 1'b0;
    issue = '0;
    repeat (RESET_CYCLES) @(posedge iClk);
    rstN <= 1'b1;
    runDirected();
    runRandom();
    driveBundle('0);
    repeat (2) @(posedge iClk);  // Let the last bundle be sampled
    errTotal = UUT.uChk.errAddSub + UUT.uChk.errCompare + UUT.uChk.errCmov
             + UUT.uChk.errMsl + UUT.uChk.errShadow + UUT.uChk.errReset;
    $display("Errors: add/sub %0d, compare %0d, cmov %0d, msl %0d, shadow %0d, reset %0d, total %0d",
             UUT.uChk.errAddSub, UUT.uChk.errCompare, UUT.uChk.errCmov,
             UUT.uChk.errMsl, UUT.uChk.errShadow, UUT.uChk.errReset, errTotal);
    if (errTotal == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: stimulus did not finish within %0d clock periods", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== tests/exStage_checker.sv ====
// Bound checker with predicate and shadow models, and the execution stage assertions
`timescale 1ns/100ps
`include "exStage_cfg.svh"

module exStage_checker
  import exStagePkg::*;
(
  input logic        iClk,
  input logic        rstN,
  input exIssue_t    issue,
  input predicates_t preds,
  input exBypass_t   bypass,
  input wbResult_t   wb
);

  // Failure counts per behavior, read by the testbench
  int errAddSub  = 0;
  int errCompare = 0;
  int errCmov    = 0;
  int errMsl     = 0;
  int errShadow  = 0;
  int errReset   = 0;

  logic                   mFlag;    // Model of flag after last edge
  logic                   mP0;
  logic                   mP1;
  logic [`DATA_WIDTH-1:0] mShadow;
  logic [`DATA_WIDTH-1:0] expAlu;
  logic [`DATA_WIDTH-1:0] expMsl;
  logic [`DATA_WIDTH-1:0] expData;
  logic                   isCmp;
  logic                   isCmov;
  logic                   expCmp;

  // ************************************************************
  // Reference rules
  // ************************************************************

  function automatic logic cmpExpect(input aluOp_u op, input logic [`DATA_WIDTH-1:0] a,
                                     input logic [`DATA_WIDTH-1:0] b);
    logic less;
    logic equal;
    equal = (a == b);
    less  = op.cmp.isUnsigned ? (a < b) : ($signed(a) < $signed(b));
    case (op.cmp.cond)
      `CMP_EQ: return equal;
      `CMP_NE: return !equal;
      `CMP_LE: return less || equal;
      `CMP_LT: return less;
      `CMP_GE: return !less;
      `CMP_GT: return !less && !equal;
      default: return 1'b0;  // Reserved conds
    endcase
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] mslExpect(input logic [`MSL_OP_WIDTH-1:0] op,
                                                       input logic [`DATA_WIDTH-1:0] a,
                                                       input logic [`DATA_WIDTH-1:0] b);
    case (op)
      `MSL_OP_OR:  return a | b;
      `MSL_OP_XOR: return a ^ b;
      `MSL_OP_MUL: return a * b;                     // Low word
      `MSL_OP_SLL: return a << b[`SHAMT_WIDTH-1:0];
      `MSL_OP_SRL: return a >> b[`SHAMT_WIDTH-1:0];
      `MSL_OP_SRA: return $signed(a) >>> b[`SHAMT_WIDTH-1:0];
      default:     return a & b;                     // AND and reserved code
    endcase
  endfunction

  assign isCmov  = (issue.alu.op.code == `ALU_OP_CMOV);
  assign isCmp   = !(isCmov || (issue.alu.op.code == `ALU_OP_ADD)
                   || (issue.alu.op.code == `ALU_OP_SUB));
  assign expCmp  = cmpExpect(issue.alu.op, issue.alu.a, issue.alu.b);
  assign expMsl  = mslExpect(issue.msl.op, issue.msl.a, issue.msl.b);
  assign expData = issue.wbCtl.selMsl ? expMsl : expAlu;

  always_comb
  begin
    if (issue.alu.op.code == `ALU_OP_ADD)
      expAlu = issue.alu.a + issue.alu.b;
    else if (isCmov)
      expAlu = mFlag ? issue.alu.a : issue.alu.b;
    else
      expAlu = issue.alu.a - issue.alu.b;  // Compares subtract too
  end

  // Models of the state elements
  always_ff @(posedge iClk or negedge rstN)
  begin
    if (!rstN)
    begin
      mFlag   <= 1'b0;
      mP0     <= 1'b0;
      mP1     <= 1'b0;
      mShadow <= '0;
    end
    else
    begin
      if (isCmp && issue.upd.updFlag)
        mFlag <= expCmp;
      if (isCmp && issue.upd.updP0)
        mP0 <= expCmp;
      if (isCmp && issue.upd.updP1)
        mP1 <= expCmp;
      if (issue.wbCtl.writeShadow)
        mShadow <= expData;
    end
  end

  // ************************************************************
  // Assertions
  // ************************************************************

  aAddSub: assert property (@(posedge iClk) disable iff (!rstN)
    (wb.addr == issue.wbCtl.rfAddr) && (wb.we == issue.wbCtl.rfWe)
    && (isCmov || ((bypass.aluResult == expAlu)
                   && (issue.wbCtl.selMsl || (wb.data == expAlu)))))
    else
    begin
      errAddSub++;
      $error("** Error %0t: ALU result or write-back address/enable mismatch", $time);
    end

  aCompare: assert property (@(posedge iClk) disable iff (!rstN)
    (preds.flag == ((isCmp && issue.upd.updFlag) ? expCmp : mFlag))
    && (preds.p0 == ((isCmp && issue.upd.updP0) ? expCmp : mP0))
    && (preds.p1 == ((isCmp && issue.upd.updP1) ? expCmp : mP1)))
    else
    begin
      errCompare++;
      $error("** Error %0t: compare result on predicates mismatch", $time);
    end

  aCmov: assert property (@(posedge iClk) disable iff (!rstN)
    isCmov |-> (bypass.aluResult == expAlu)
               && (issue.wbCtl.selMsl || (wb.data == expAlu)))
    else
    begin
      errCmov++;
      $error("** Error %0t: cmov picked the wrong operand", $time);
    end

  aMsl: assert property (@(posedge iClk) disable iff (!rstN)
    (bypass.mslResult == expMsl) && (!issue.wbCtl.selMsl || (wb.data == expMsl)))
    else
    begin
      errMsl++;
      $error("** Error %0t: multiply/shift/logic result mismatch", $time);
    end

  aShadow: assert property (@(posedge iClk) disable iff (!rstN)
    bypass.shadow == mShadow)
    else
    begin
      errShadow++;
      $error("** Error %0t: shadow register mismatch", $time);
    end

  aReset: assert property (@(posedge iClk)
    (!rstN || $rose(rstN)) |-> ((preds == '0) && (bypass.shadow == '0)))
    else
    begin
      errReset++;
      $error("** Error %0t: predicates or shadow not cleared by reset", $time);
    end

endmodule

bind exStage exStage_checker uChk (
  .iClk   (iClk),
  .rstN   (rstN),
  .issue  (issue),
  .preds  (preds),
  .bypass (bypass),
  .wb     (wb)
);
